// File: design/l1_pkg.sv
package l1_pkg;

    // byte address with bits 1:0 always zero
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // instruction cache operations
    typedef enum logic {
        IOP_FETCH     = 1'b0,
        IOP_INDEX_INV = 1'b1
    } iop_t;

    // data cache operations
    typedef enum logic {
        DOP_LOAD  = 1'b0,
        DOP_STORE = 1'b1
    } dop_t;

    // 16 lines per cache
    localparam int DEF_INDEX_W = 4;

    // credits held by the arbiter after reset
    localparam int DEF_MEM_CREDITS = 2;

endpackage

// File: design/mem_client_if.sv
interface mem_client_if;

    logic                      req;
    logic                      write;
    logic [l1_pkg::addr_w-1:0] addr;
    logic [l1_pkg::data_w-1:0] wdata;
    logic                      grant;
    logic                      rvalid;
    logic [l1_pkg::data_w-1:0] rdata;

    modport cache (
        output req, write, addr, wdata,
        input  grant, rvalid, rdata
    );

    modport arb (
        input  req, write, addr, wdata,
        output grant, rvalid, rdata
    );

endinterface

// File: design/icache_ctrl.sv
module icache_ctrl #(
    parameter int INDEX_W = l1_pkg::DEF_INDEX_W
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      in_valid,
    input  l1_pkg::iop_t              op,
    input  logic [l1_pkg::addr_w-1:0] addr,
    input  logic                      cached,
    output logic                      ready,
    output logic                      resp_valid,
    output logic [l1_pkg::data_w-1:0] rdata,
    mem_client_if.cache               mem
);

    localparam int TAG_W = l1_pkg::addr_w - INDEX_W - 2;
    localparam int LINES = 2 ** INDEX_W;

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS_REQ, MISS_WAIT, INV} state_t;

    state_t state;

    logic [TAG_W-1:0]          tag_arr [LINES];
    logic [l1_pkg::data_w-1:0] data_arr [LINES];
    logic [LINES-1:0]          valid;

    logic [l1_pkg::addr_w-1:0] addr_q;
    logic                      cached_q;
    logic [INDEX_W-1:0]        idx;
    logic [TAG_W-1:0]          tag;
    logic                      hit;

    assign idx = addr_q[INDEX_W+1:2];
    assign tag = addr_q[l1_pkg::addr_w-1:INDEX_W+2];
    assign hit = valid[idx] && (tag_arr[idx] == tag);

    assign ready     = (state == IDLE);
    assign mem.req   = (state == MISS_REQ);
    assign mem.write = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
            valid      <= '0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        if (op == l1_pkg::IOP_INDEX_INV) begin
                            // response goes out while the bit is cleared
                            state      <= INV;
                            resp_valid <= 1'b1;
                        end else if (cached) begin
                            state <= LOOKUP;
                        end else begin
                            state <= MISS_REQ;
                        end
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state      <= IDLE;
                        resp_valid <= 1'b1;
                    end else begin
                        state <= MISS_REQ;
                    end
                end
                MISS_REQ: begin
                    if (mem.grant) begin
                        state <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (mem.rvalid) begin
                        state      <= IDLE;
                        resp_valid <= 1'b1;
                        if (cached_q) begin
                            valid[idx] <= 1'b1;
                        end
                    end
                end
                INV: begin
                    valid[idx] <= 1'b0;
                    state      <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request capture, arrays and read data
    always_ff @(posedge clk) begin
        if (state == IDLE && in_valid) begin
            addr_q   <= addr;
            cached_q <= cached;
        end
        if (state == LOOKUP && hit) begin
            rdata <= data_arr[idx];
        end
        if (state == MISS_WAIT && mem.rvalid) begin
            rdata <= mem.rdata;
            if (cached_q) begin
                tag_arr[idx]  <= tag;
                data_arr[idx] <= mem.rdata;
            end
        end
    end

endmodule

// File: design/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int INDEX_W = l1_pkg::DEF_INDEX_W
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      in_valid,
    input  l1_pkg::dop_t              op,
    input  logic [l1_pkg::addr_w-1:0] addr,
    input  logic [l1_pkg::data_w-1:0] wdata,
    input  logic                      cached,
    output logic                      ready,
    output logic                      resp_valid,
    output logic [l1_pkg::data_w-1:0] rdata,
    mem_client_if.cache               mem
);

    localparam int TAG_W = l1_pkg::addr_w - INDEX_W - 2;
    localparam int LINES = 2 ** INDEX_W;

    typedef enum logic [2:0] {IDLE, LOOKUP, RD_REQ, RD_WAIT, WR_REQ} state_t;

    state_t state;

    logic [TAG_W-1:0]          tag_arr [LINES];
    logic [l1_pkg::data_w-1:0] data_arr [LINES];
    logic [LINES-1:0]          valid;

    logic [l1_pkg::addr_w-1:0] addr_q;
    logic [l1_pkg::data_w-1:0] wdata_q;
    logic                      cached_q;
    logic [INDEX_W-1:0]        idx;
    logic [TAG_W-1:0]          tag;
    logic                      hit;

    assign idx = addr_q[INDEX_W+1:2];
    assign tag = addr_q[l1_pkg::addr_w-1:INDEX_W+2];
    assign hit = valid[idx] && (tag_arr[idx] == tag);

    assign ready     = (state == IDLE);
    assign mem.req   = (state == RD_REQ) || (state == WR_REQ);
    assign mem.write = (state == WR_REQ);
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= IDLE;
            resp_valid <= 1'b0;
            valid      <= '0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (in_valid) begin
                        // every store goes straight to memory
                        if (op == l1_pkg::DOP_STORE) begin
                            state <= WR_REQ;
                        end else if (cached) begin
                            state <= LOOKUP;
                        end else begin
                            state <= RD_REQ;
                        end
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state      <= IDLE;
                        resp_valid <= 1'b1;
                    end else begin
                        state <= RD_REQ;
                    end
                end
                RD_REQ: begin
                    if (mem.grant) begin
                        state <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    if (mem.rvalid) begin
                        state      <= IDLE;
                        resp_valid <= 1'b1;
                        if (cached_q) begin
                            valid[idx] <= 1'b1;
                        end
                    end
                end
                WR_REQ: begin
                    // write is done once granted
                    if (mem.grant) begin
                        state      <= IDLE;
                        resp_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && in_valid) begin
            addr_q   <= addr;
            wdata_q  <= wdata;
            cached_q <= cached;
        end
        if (state == LOOKUP && hit) begin
            rdata <= data_arr[idx];
        end
        if (state == RD_WAIT && mem.rvalid) begin
            rdata <= mem.rdata;
            if (cached_q) begin
                tag_arr[idx]  <= tag;
                data_arr[idx] <= mem.rdata;
            end
        end
        // no allocate on a store miss
        if (state == WR_REQ && mem.grant && cached_q && hit) begin
            data_arr[idx] <= wdata_q;
        end
    end

endmodule

// File: design/mem_arbiter.sv
module mem_arbiter #(
    parameter int MEM_CREDITS = l1_pkg::DEF_MEM_CREDITS
) (
    input  logic                      clk,
    input  logic                      rstn,
    mem_client_if.arb                 icache,
    mem_client_if.arb                 dcache,
    output logic                      mem_req,
    output logic                      mem_write,
    output logic [l1_pkg::addr_w-1:0] mem_addr,
    output logic [l1_pkg::data_w-1:0] mem_wdata,
    input  logic                      mem_credit,
    input  logic                      mem_rvalid,
    input  logic [l1_pkg::data_w-1:0] mem_rdata
);

    localparam int CNT_W = $clog2(MEM_CREDITS + 1);
    localparam int PTR_W = (MEM_CREDITS > 1) ? $clog2(MEM_CREDITS) : 1;

    logic [CNT_W-1:0] credits;
    logic [CNT_W-1:0] avail;
    logic [CNT_W-1:0] q_count;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             q_owner [MEM_CREDITS];
    logic             can_issue;
    logic             sel_d;
    logic             any_grant;
    logic             enq;

    // the issue in flight on mem_req still holds its credit
    assign avail     = credits - CNT_W'(mem_req);
    assign can_issue = (avail != '0) && (q_count != CNT_W'(MEM_CREDITS));

    // data cache wins ties
    assign sel_d         = dcache.req;
    assign dcache.grant  = dcache.req && can_issue;
    assign icache.grant  = icache.req && !dcache.req && can_issue;
    assign any_grant     = icache.grant || dcache.grant;
    assign enq           = any_grant && !(sel_d ? dcache.write : icache.write);

    // returns follow request order
    assign dcache.rvalid = mem_rvalid && q_owner[rd_ptr];
    assign icache.rvalid = mem_rvalid && !q_owner[rd_ptr];
    assign dcache.rdata  = mem_rdata;
    assign icache.rdata  = mem_rdata;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_req <= 1'b0;
            credits <= CNT_W'(MEM_CREDITS);
            q_count <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
        end else begin
            mem_req <= any_grant;
            credits <= credits - CNT_W'(mem_req) + CNT_W'(mem_credit);
            q_count <= q_count + CNT_W'(enq) - CNT_W'(mem_rvalid);
            if (enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(MEM_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (mem_rvalid) begin
                rd_ptr <= (rd_ptr == PTR_W'(MEM_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_grant) begin
            mem_write <= sel_d ? dcache.write : icache.write;
            mem_addr  <= sel_d ? dcache.addr : icache.addr;
            mem_wdata <= sel_d ? dcache.wdata : icache.wdata;
        end
        if (enq) begin
            q_owner[wr_ptr] <= sel_d;
        end
    end

endmodule

// File: design/l1_cache_top.sv
module l1_cache_top #(
    parameter int INDEX_W     = l1_pkg::DEF_INDEX_W,
    parameter int MEM_CREDITS = l1_pkg::DEF_MEM_CREDITS
) (
    input  logic                      clk,
    input  logic                      rstn,

    input  logic                      i_in_valid,
    input  l1_pkg::iop_t              i_op,
    input  logic [l1_pkg::addr_w-1:0] i_addr,
    input  logic                      i_cached,
    output logic                      i_ready,
    output logic                      i_resp_valid,
    output logic [l1_pkg::data_w-1:0] i_rdata,

    input  logic                      d_in_valid,
    input  l1_pkg::dop_t              d_op,
    input  logic [l1_pkg::addr_w-1:0] d_addr,
    input  logic [l1_pkg::data_w-1:0] d_wdata,
    input  logic                      d_cached,
    output logic                      d_ready,
    output logic                      d_resp_valid,
    output logic [l1_pkg::data_w-1:0] d_rdata,

    output logic                      mem_req,
    output logic                      mem_write,
    output logic [l1_pkg::addr_w-1:0] mem_addr,
    output logic [l1_pkg::data_w-1:0] mem_wdata,
    input  logic                      mem_credit,
    input  logic                      mem_rvalid,
    input  logic [l1_pkg::data_w-1:0] mem_rdata
);

    mem_client_if icache_mem ();
    mem_client_if dcache_mem ();

    icache_ctrl #(
        .INDEX_W(INDEX_W)
    ) icache0 (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (i_in_valid),
        .op        (i_op),
        .addr      (i_addr),
        .cached    (i_cached),
        .ready     (i_ready),
        .resp_valid(i_resp_valid),
        .rdata     (i_rdata),
        .mem       (icache_mem.cache)
    );

    dcache_ctrl #(
        .INDEX_W(INDEX_W)
    ) dcache0 (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (d_in_valid),
        .op        (d_op),
        .addr      (d_addr),
        .wdata     (d_wdata),
        .cached    (d_cached),
        .ready     (d_ready),
        .resp_valid(d_resp_valid),
        .rdata     (d_rdata),
        .mem       (dcache_mem.cache)
    );

    mem_arbiter #(
        .MEM_CREDITS(MEM_CREDITS)
    ) arb0 (
        .clk       (clk),
        .rstn      (rstn),
        .icache    (icache_mem.arb),
        .dcache    (dcache_mem.arb),
        .mem_req   (mem_req),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_credit(mem_credit),
        .mem_rvalid(mem_rvalid),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: tb/l1_cache_asserts.sv
module l1_cache_asserts #(
    parameter int MEM_CREDITS = l1_pkg::DEF_MEM_CREDITS,
    parameter int CNT_W       = 2
) (
    input logic             clk,
    input logic             rstn,
    input logic             mem_req,
    input logic [CNT_W-1:0] credits,
    input logic             mem_rvalid,
    input logic [CNT_W-1:0] q_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // a request in flight must hold a credit
    assert property (@(posedge clk) disable iff (!rstn) mem_req |-> credits != '0)
        else $error("mem_req issued with zero credits");

    assert property (@(posedge clk) disable iff (!rstn) credits <= CNT_W'(MEM_CREDITS))
        else $error("credit count above MEM_CREDITS");

    // read data only comes back for a read still in the queue
    assert property (@(posedge clk) disable iff (!rstn) mem_rvalid |-> q_count != '0)
        else $error("read data returned with no read outstanding");

endmodule

bind mem_arbiter l1_cache_asserts #(
    .MEM_CREDITS(MEM_CREDITS),
    .CNT_W      (CNT_W)
) asserts0 (
    .clk       (clk),
    .rstn      (rstn),
    .mem_req   (mem_req),
    .credits   (credits),
    .mem_rvalid(mem_rvalid),
    .q_count   (q_count)
);

// File: tb/l1_cache_tb.sv
module l1_cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int INDEX_W     = l1_pkg::DEF_INDEX_W;
    localparam int MEM_CREDITS = l1_pkg::DEF_MEM_CREDITS;
    localparam int MEM_WORDS   = 256;

    logic                      clk;
    logic                      rstn;
    logic                      i_in_valid;
    l1_pkg::iop_t              i_op;
    logic [l1_pkg::addr_w-1:0] i_addr;
    logic                      i_cached;
    logic                      i_ready;
    logic                      i_resp_valid;
    logic [l1_pkg::data_w-1:0] i_rdata;
    logic                      d_in_valid;
    l1_pkg::dop_t              d_op;
    logic [l1_pkg::addr_w-1:0] d_addr;
    logic [l1_pkg::data_w-1:0] d_wdata;
    logic                      d_cached;
    logic                      d_ready;
    logic                      d_resp_valid;
    logic [l1_pkg::data_w-1:0] d_rdata;
    logic                      mem_req;
    logic                      mem_write;
    logic [l1_pkg::addr_w-1:0] mem_addr;
    logic [l1_pkg::data_w-1:0] mem_wdata;
    logic                      mem_credit;
    logic                      mem_rvalid;
    logic [l1_pkg::data_w-1:0] mem_rdata;

    // memory model
    logic [l1_pkg::data_w-1:0] mem [MEM_WORDS];
    logic [l1_pkg::data_w-1:0] rd_data_q [$];
    logic [l1_pkg::addr_w-1:0] rd_addr_log [$];
    int                        rd_due_q [$];
    int                        credit_due_q [$];
    int                        seed  = 30989;
    int                        cycle = 0;
    int                        limit = 0;

    // one entry per line of the cases file
    string                     case_port [$];
    int                        case_op [$];
    logic [l1_pkg::addr_w-1:0] case_addr [$];
    logic [l1_pkg::data_w-1:0] case_wdata [$];
    int                        case_cached [$];
    logic [l1_pkg::data_w-1:0] case_exp [$];
    int                        case_reads [$];
    int                        case_conc [$];

    l1_cache_top #(
        .INDEX_W    (INDEX_W),
        .MEM_CREDITS(MEM_CREDITS)
    ) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input logic [l1_pkg::data_w-1:0] got,
                              input logic [l1_pkg::data_w-1:0] exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %0t %s rdata %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input logic [l1_pkg::addr_w-1:0] got,
                              input logic [l1_pkg::addr_w-1:0] exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %0t %s addr %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_reads(input int got, input int exp, input string what);
        if (got != exp) begin
            report_failure($sformatf("[FAIL] %0t %s made %0d reads, expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    // credit and read delays of 1 to 4 cycles kept in order
    function automatic int next_due(input int tail);
        int due;
        due = cycle + 1 + ($unsigned($random(seed)) % 4);
        if (due <= tail) begin
            due = tail + 1;
        end
        return due;
    endfunction

    always @(posedge clk) begin
        cycle++;
        if (limit > 0 && cycle >= limit) begin
            report_failure("timeout waiting for response");
        end
        if (rstn) begin
            mem_credit <= 1'b0;
            mem_rvalid <= 1'b0;
            if (mem_req) begin
                credit_due_q.push_back(next_due(credit_due_q.size() ? credit_due_q[$] : -1));
                if (mem_write) begin
                    mem[mem_addr[9:2]] = mem_wdata;
                end else begin
                    rd_addr_log.push_back(mem_addr);
                    rd_data_q.push_back(mem[mem_addr[9:2]]);
                    rd_due_q.push_back(next_due(rd_due_q.size() ? rd_due_q[$] : -1));
                end
            end
            if (credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
                mem_credit <= 1'b1;
                void'(credit_due_q.pop_front());
            end
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle) begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end
        end
    end

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        string port;
        int    op;
        int    cached;
        int    reads;
        int    conc;
        logic [l1_pkg::addr_w-1:0] addr;
        logic [l1_pkg::data_w-1:0] wdata;
        logic [l1_pkg::data_w-1:0] exp;
        fd = $fopen("tb/l1_cases.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the cases file tb/l1_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %h %h %d %h %d %d",
                        port, op, addr, wdata, cached, exp, reads, conc);
            if (n == 8) begin
                case_port.push_back(port);
                case_op.push_back(op);
                case_addr.push_back(addr);
                case_wdata.push_back(wdata);
                case_cached.push_back(cached);
                case_exp.push_back(exp);
                case_reads.push_back(reads);
                case_conc.push_back(conc);
            end
        end
        $fclose(fd);
        if (case_port.size() == 0) begin
            report_failure("the cases file holds no cases");
        end
    endtask

    // issues one case or two together and waits for every response
    task automatic run_step(input int first, input int count);
        int i_k;
        int d_k;
        int j;
        int reads_before;
        int exp_reads;
        i_k = -1;
        d_k = -1;
        exp_reads = 0;
        @(posedge clk);
        while (!i_ready || !d_ready) begin
            @(posedge clk);
        end
        reads_before = rd_addr_log.size();
        for (j = first; j < first + count; j++) begin
            exp_reads += case_reads[j];
            if (case_port[j] == "I") begin
                i_k = j;
                i_in_valid <= 1'b1;
                i_op       <= l1_pkg::iop_t'(case_op[j]);
                i_addr     <= case_addr[j];
                i_cached   <= case_cached[j][0];
            end else begin
                d_k = j;
                d_in_valid <= 1'b1;
                d_op       <= l1_pkg::dop_t'(case_op[j]);
                d_addr     <= case_addr[j];
                d_wdata    <= case_wdata[j];
                d_cached   <= case_cached[j][0];
            end
        end
        @(posedge clk);
        i_in_valid <= 1'b0;
        d_in_valid <= 1'b0;
        while (i_k >= 0 || d_k >= 0) begin
            @(posedge clk);
            if (i_k >= 0 && i_resp_valid) begin
                if (case_op[i_k] == int'(l1_pkg::IOP_FETCH)) begin
                    check_word(i_rdata, case_exp[i_k], $sformatf("case %0d fetch", i_k));
                end
                i_k = -1;
            end
            if (d_k >= 0 && d_resp_valid) begin
                if (case_op[d_k] == int'(l1_pkg::DOP_LOAD)) begin
                    check_word(d_rdata, case_exp[d_k], $sformatf("case %0d load", d_k));
                end
                d_k = -1;
            end
        end
        check_reads(rd_addr_log.size() - reads_before, exp_reads,
                    $sformatf("case %0d", first));
        // data cache wins the tie on concurrent misses
        if (count == 2 && exp_reads == 2) begin
            for (j = first; j < first + count; j++) begin
                if (case_port[j] == "D") begin
                    check_addr(rd_addr_log[reads_before], case_addr[j],
                               $sformatf("case %0d first read", first));
                end
            end
        end
    endtask

    initial begin
        int k;
        rstn       = 1'b0;
        i_in_valid = 1'b0;
        i_op       = l1_pkg::IOP_FETCH;
        i_addr     = '0;
        i_cached   = 1'b0;
        d_in_valid = 1'b0;
        d_op       = l1_pkg::DOP_LOAD;
        d_addr     = '0;
        d_wdata    = '0;
        d_cached   = 1'b0;
        mem_credit = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        // every word holds its own byte address inverted
        for (k = 0; k < MEM_WORDS; k++) begin
            mem[k] = ~(32'(k) << 2);
        end
        load_cases();
        limit = case_port.size() * 40;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        k = 0;
        while (k < case_port.size()) begin
            if (case_conc[k] != 0 && k + 1 < case_port.size()) begin
                run_step(k, 2);
                k += 2;
            end else begin
                run_step(k, 1);
                k += 1;
            end
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: tb/l1_cases.txt
# port op(0 fetch/load, 1 inv/store) addr wdata cached exp_rdata exp_reads concurrent
# concurrent 1 issues the line together with the next one
I 0 00000010 00000000 1 ffffffef 1 0
I 0 00000010 00000000 1 ffffffef 0 0
I 0 00000020 00000000 0 ffffffdf 1 0
I 0 00000020 00000000 0 ffffffdf 1 0
I 1 00000010 00000000 1 00000000 0 0
I 0 00000010 00000000 1 ffffffef 1 0
D 0 00000080 00000000 1 ffffff7f 1 0
D 1 00000080 12345678 1 00000000 0 0
D 0 00000080 00000000 1 12345678 0 0
D 1 000000c4 cafef00d 1 00000000 0 0
D 0 000000c4 00000000 1 cafef00d 1 0
D 0 00000104 00000000 1 fffffefb 1 0
D 0 000000c4 00000000 1 cafef00d 1 0
I 0 00000050 00000000 1 ffffffaf 1 0
I 0 00000010 00000000 1 ffffffef 1 0
I 0 00000200 00000000 1 fffffdff 1 1
D 0 00000300 00000000 1 fffffcff 1 0
I 0 000003f0 00000000 1 fffffc0f 1 1
D 0 000003f4 00000000 1 fffffc0b 1 0

// File: sim.f
design/l1_pkg.sv
design/mem_client_if.sv
design/icache_ctrl.sv
design/dcache_ctrl.sv
design/mem_arbiter.sv
design/l1_cache_top.sv
tb/l1_cache_asserts.sv
tb/l1_cache_tb.sv

// File: Bender.yml
package:
  name: l1_cache

sources:
  - design/l1_pkg.sv
  - design/mem_client_if.sv
  - design/icache_ctrl.sv
  - design/dcache_ctrl.sv
  - design/mem_arbiter.sv
  - design/l1_cache_top.sv
  - target: test
    files:
      - tb/l1_cache_asserts.sv
      - tb/l1_cache_tb.sv
